//--- sources.f
+incdir+testbench
source/chess_pkg.sv
source/move_gen_fsm.sv
source/square_counter.sv
source/ray_stepper.sv
source/move_builder.sv
source/move_store.sv
source/move_gen_top.sv
testbench/move_gen_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = move_gen_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/move_model.svh
`ifndef MOVE_MODEL_SVH
`define MOVE_MODEL_SVH

chess_pkg::board_t exp_board [$];     // expected positions in store order
logic              exp_capture [$];

function automatic chess_pkg::piece_t piece_at(chess_pkg::board_t b, int sq);
   return b[sq * 4 +: 4];
endfunction

function automatic chess_pkg::board_t put_piece(chess_pkg::board_t b, int sq,
                                                chess_pkg::piece_t p);
   chess_pkg::board_t nb;
   nb = b;
   nb[sq * 4 +: 4] = p;
   return nb;
endfunction

// squares 0..63, directions in table order, sliders walk outward
task automatic list_moves(input chess_pkg::board_t b, input logic white);
   chess_pkg::piece_t p;
   chess_pkg::piece_t t;
   logic [2:0]        kind;
   logic              slider;
   logic              stop;
   int                r;
   int                c;
   exp_board.delete();
   exp_capture.delete();
   for (int sq = 0; sq < 64; sq++)
   begin
      p    = piece_at(b, sq);
      kind = p[2:0];
      if (p[3] == white || kind < chess_pkg::piece_knight || kind > chess_pkg::piece_king)
         continue;   // not a mover of this side
      slider = (kind == chess_pkg::piece_bishop) || (kind == chess_pkg::piece_rook) ||
               (kind == chess_pkg::piece_queen);
      for (int d = 0; d < int'(chess_pkg::dir_count[kind]); d++)
      begin
         r    = sq / 8;
         c    = sq % 8;
         stop = 1'b0;
         while (!stop)
         begin
            r = r + int'(chess_pkg::row_offset[kind][d]);
            c = c + int'(chess_pkg::col_offset[kind][d]);
            if (r < 0 || r > 7 || c < 0 || c > 7)
               stop = 1'b1;   // off the edge
            else
            begin
               t = piece_at(b, r * 8 + c);
               if (t[2:0] != chess_pkg::piece_empty && t[3] == p[3])
                  stop = 1'b1;   // own piece blocks
               else
               begin
                  exp_board.push_back(put_piece(put_piece(b, sq, 4'h0), r * 8 + c, p));
                  exp_capture.push_back(t[2:0] != chess_pkg::piece_empty);
                  stop = !slider || (t[2:0] != chess_pkg::piece_empty);
               end
            end
         end
      end
   end
endtask

`endif

//--- testbench/move_gen_tb.sv
`timescale 1ns/100ps

module move_gen_tb;

   localparam int table_rows    = 9;
   localparam int random_boards = 24;
   localparam int run_limit     = 4000;   // cycles
   localparam int clear_limit   = 4;

   logic                   clk;
   logic                   reset;
   logic                   board_valid;
   chess_pkg::board_t      board_in;
   logic                   white_to_move_in;
   chess_pkg::move_index_t move_index;
   logic                   clear_moves;
   logic                   moves_ready;
   chess_pkg::move_count_t move_count;
   chess_pkg::board_t      board_out;
   logic                   capture_out;
   logic                   white_to_move_out;

   integer seed;
   int     errors;
   int     timeouts;

   chess_pkg::board_t      tbl_board [table_rows];
   logic                   tbl_white [table_rows] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
                                                      1'b1, 1'b0, 1'b1, 1'b0};
   chess_pkg::move_count_t tbl_count [table_rows] = '{8'd2, 8'd8, 8'd5, 8'd2, 8'd22,
                                                      8'd2, 8'd8, 8'd0, 8'd0};

   `include "move_model.svh"

   move_gen_top dut0
   (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .board_in          (board_in),
      .white_to_move_in  (white_to_move_in),
      .move_index        (move_index),
      .clear_moves       (clear_moves),
      .moves_ready       (moves_ready),
      .move_count        (move_count),
      .board_out         (board_out),
      .capture_out       (capture_out),
      .white_to_move_out (white_to_move_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [255:0] got,
                              input logic [255:0] expected);
      if (got !== expected)
      begin
         errors++;
         $display("Mismatch %s: got %0h, expected %0h", name, got, expected);
      end
   endtask

   task automatic build_table();
      tbl_board[0] = put_piece('0, 0, 4'h2);   // knight a1
      tbl_board[1] = put_piece('0, 27, 4'h2);  // knight d4
      // rook a1, own pawn a4, black knight d1
      tbl_board[2] = put_piece(put_piece(put_piece('0, 0, 4'h4), 24, 4'h1), 3, 4'hA);
      // bishop c1, own pawn e3, black rook b2
      tbl_board[3] = put_piece(put_piece(put_piece('0, 2, 4'h3), 20, 4'h1), 9, 4'hC);
      // queen d4, own pawn d6, black pawn f6
      tbl_board[4] = put_piece(put_piece(put_piece('0, 27, 4'h5), 43, 4'h1), 45, 4'h9);
      tbl_board[5] = put_piece(put_piece('0, 0, 4'h2), 36, 4'hE);   // knight a1, black king e5
      tbl_board[6] = tbl_board[5];
      tbl_board[7] = '0;
      for (int c = 0; c < 8; c++)
      begin
         tbl_board[7] = put_piece(tbl_board[7], 8 + c, 4'h1);
         tbl_board[7] = put_piece(tbl_board[7], 48 + c, 4'h9);
      end
      tbl_board[8] = '0;
   endtask

   task automatic random_board(output chess_pkg::board_t b, output logic white);
      int value;
      int pieces;
      int tries;
      tries = 0;
      do
      begin
         b      = '0;
         value  = $random(seed);
         pieces = 1 + (value & 32'h7fff) % 6;
         white  = value[16];
         for (int k = 0; k < pieces; k++)
         begin
            value = $random(seed);
            b     = put_piece(b, value & 63, {value[8], 3'(1 + (value[23:16] % 6))});
         end
         list_moves(b, white);
         tries++;
      end
      while (exp_board.size() > chess_pkg::max_moves && tries < 16);   // keep within memory
   endtask

   task automatic apply_board(input chess_pkg::board_t b, input logic white,
                              input chess_pkg::move_count_t expected);
      int cycles;
      list_moves(b, white);
      @(posedge clk);
      #1;
      board_in         = b;
      white_to_move_in = white;
      board_valid      = 1'b1;
      @(posedge clk);
      #1;
      board_valid = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      board_in         = ~b;   // stray start while busy
      white_to_move_in = !white;
      board_valid      = 1'b1;
      @(posedge clk);
      #1;
      board_valid = 1'b0;
      cycles      = 0;
      while (!moves_ready && cycles < run_limit)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!moves_ready)
      begin
         $display("Timeout: moves_ready did not rise within %0d cycles", run_limit);
         timeouts++;
         return;
      end
      check_value("move_count", 256'(move_count), 256'(expected));
      for (int i = 0; i < exp_board.size(); i++)
      begin
         move_index = chess_pkg::move_index_t'(i);
         @(posedge clk);
         #1;
         check_value($sformatf("board_out[%0d]", i), board_out, exp_board[i]);
         check_value($sformatf("capture_out[%0d]", i), 256'(capture_out), 256'(exp_capture[i]));
         check_value($sformatf("white_to_move_out[%0d]", i), 256'(white_to_move_out),
                     256'(!white));
      end
      check_value("moves_ready", 256'(moves_ready), 256'(1'b1));
      clear_moves = 1'b1;
      @(posedge clk);
      #1;
      clear_moves = 1'b0;
      cycles      = 0;
      while (moves_ready && cycles < clear_limit)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (moves_ready)
      begin
         $display("Timeout: moves_ready stayed high after clear_moves");
         timeouts++;
      end
   endtask

   initial
   begin
      chess_pkg::board_t b;
      logic              w;
      seed             = 32'hf707_a794;
      errors           = 0;
      timeouts         = 0;
      reset            = 1'b1;
      board_valid      = 1'b0;
      board_in         = '0;
      white_to_move_in = 1'b1;
      move_index       = '0;
      clear_moves      = 1'b0;
      build_table();
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      check_value("moves_ready", 256'(moves_ready), 256'(1'b0));
      for (int row = 0; row < table_rows && timeouts == 0; row++)
         apply_board(tbl_board[row], tbl_white[row], tbl_count[row]);
      for (int n = 0; n < random_boards && timeouts == 0; n++)
      begin
         random_board(b, w);
         apply_board(b, w, chess_pkg::move_count_t'(exp_board.size()));
      end
      $display("Done: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- source/move_gen_top.sv
`timescale 1ns/100ps

module move_gen_top
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_valid,
   input  chess_pkg::board_t      board_in,
   input  logic                   white_to_move_in,
   input  chess_pkg::move_index_t move_index,
   input  logic                   clear_moves,
   output logic                   moves_ready,
   output chess_pkg::move_count_t move_count,
   output chess_pkg::board_t      board_out,
   output logic                   capture_out,
   output logic                   white_to_move_out
);

   logic               load;
   logic               dir_start;
   logic               step;
   logic               next_dir;
   logic               next_square;
   logic               record;
   chess_pkg::square_t square;
   chess_pkg::dir_t    dir;
   chess_pkg::square_t target;
   logic               on_board;
   logic               is_slider;
   logic               dir_last;
   logic [2:0]         kind;
   logic               own_piece;
   logic               target_empty;
   logic               target_enemy;
   chess_pkg::board_t  new_board;
   logic               capture;
   logic               white_to_move;

   move_gen_fsm fsm0
   (
      .clk          (clk),
      .reset        (reset),
      .board_valid  (board_valid),
      .clear_moves  (clear_moves),
      .own_piece    (own_piece),
      .is_slider    (is_slider),
      .dir_last     (dir_last),
      .square_last  (&square),
      .on_board     (on_board),
      .target_empty (target_empty),
      .target_enemy (target_enemy),
      .load         (load),
      .dir_start    (dir_start),
      .step         (step),
      .next_dir     (next_dir),
      .next_square  (next_square),
      .record       (record),
      .moves_ready  (moves_ready)
   );

   square_counter counter0
   (
      .clk         (clk),
      .reset       (reset),
      .load        (load),
      .next_square (next_square),
      .next_dir    (next_dir),
      .dir_start   (dir_start),
      .square      (square),
      .dir         (dir)
   );

   ray_stepper stepper0
   (
      .clk       (clk),
      .square    (square),
      .dir       (dir),
      .kind      (kind),
      .dir_start (dir_start),
      .step      (step),
      .target    (target),
      .on_board  (on_board),
      .is_slider (is_slider),
      .dir_last  (dir_last)
   );

   move_builder builder0
   (
      .clk              (clk),
      .load             (load),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .square           (square),
      .target           (target),
      .kind             (kind),
      .own_piece        (own_piece),
      .target_empty     (target_empty),
      .target_enemy     (target_enemy),
      .new_board        (new_board),
      .capture          (capture),
      .white_to_move    (white_to_move)
   );

   move_store store0
   (
      .clk               (clk),
      .load              (load),
      .record            (record),
      .new_board         (new_board),
      .capture           (capture),
      .white_to_move     (white_to_move),
      .move_index        (move_index),
      .move_count        (move_count),
      .board_out         (board_out),
      .capture_out       (capture_out),
      .white_to_move_out (white_to_move_out)
   );

endmodule

//--- source/move_store.sv
`timescale 1ns/100ps

module move_store
(
   input  logic                   clk,
   input  logic                   load,
   input  logic                   record,
   input  chess_pkg::board_t      new_board,
   input  logic                   capture,
   input  logic                   white_to_move,
   input  chess_pkg::move_index_t move_index,
   output chess_pkg::move_count_t move_count,
   output chess_pkg::board_t      board_out,
   output logic                   capture_out,
   output logic                   white_to_move_out
);

   chess_pkg::board_t      board_mem   [chess_pkg::max_moves];
   logic                   capture_mem [chess_pkg::max_moves];
   logic                   side_mem    [chess_pkg::max_moves];
   chess_pkg::move_count_t count;
   chess_pkg::move_index_t wr_addr;

   assign wr_addr = chess_pkg::move_index_t'(count);

   always_ff @(posedge clk)
   begin
      if (load)
         count <= '0;
      else if (record)
         count <= count + chess_pkg::move_count_t'(1);
   end

   always_ff @(posedge clk)
   begin
      if (record)
      begin
         board_mem[wr_addr]   <= new_board;
         capture_mem[wr_addr] <= capture;
         side_mem[wr_addr]    <= !white_to_move;   // other side moves next
      end
   end

   // one cycle read
   always_ff @(posedge clk)
   begin
      board_out         <= board_mem[move_index];
      capture_out       <= capture_mem[move_index];
      white_to_move_out <= side_mem[move_index];
   end

   assign move_count = count;

   // memory full, a further move would overwrite entry 0
   assert property (@(posedge clk) record |-> count != chess_pkg::move_count_t'(chess_pkg::max_moves));

endmodule

//--- source/move_builder.sv
`timescale 1ns/100ps

module move_builder
(
   input  logic               clk,
   input  logic               load,
   input  chess_pkg::board_t  board_in,
   input  logic               white_to_move_in,
   input  chess_pkg::square_t square,
   input  chess_pkg::square_t target,
   output logic [2:0]         kind,
   output logic               own_piece,
   output logic               target_empty,
   output logic               target_enemy,
   output chess_pkg::board_t  new_board,
   output logic               capture,
   output logic               white_to_move
);

   chess_pkg::board_t board;
   chess_pkg::piece_t piece;
   chess_pkg::piece_t target_piece;
   logic              black_to_move;

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         board         <= board_in;
         white_to_move <= white_to_move_in;
      end
   end

   assign black_to_move = !white_to_move;
   assign piece         = board[{square, 2'b00} +: $bits(chess_pkg::piece_t)];
   assign target_piece  = board[{target, 2'b00} +: $bits(chess_pkg::piece_t)];
   assign kind          = piece[2:0];

   // pawns block and can be taken but never move here
   assign own_piece = (piece[chess_pkg::black_bit] == black_to_move) &&
                      (kind >= chess_pkg::piece_knight) &&
                      (kind <= chess_pkg::piece_king);

   assign target_empty = (target_piece[2:0] == chess_pkg::piece_empty);
   assign target_enemy = !target_empty &&
                         (target_piece[chess_pkg::black_bit] != black_to_move);
   assign capture      = target_enemy;

   always_comb
   begin
      new_board = board;
      new_board[{square, 2'b00} +: $bits(chess_pkg::piece_t)] =
         chess_pkg::piece_t'(chess_pkg::piece_empty);
      new_board[{target, 2'b00} +: $bits(chess_pkg::piece_t)] = piece;
   end

endmodule

//--- source/ray_stepper.sv
`timescale 1ns/100ps

module ray_stepper
(
   input  logic               clk,
   input  chess_pkg::square_t square,
   input  chess_pkg::dir_t    dir,
   input  logic [2:0]         kind,
   input  logic               dir_start,
   input  logic               step,
   output chess_pkg::square_t target,
   output logic               on_board,
   output logic               is_slider,
   output logic               dir_last
);

   chess_pkg::coord_t row;
   chess_pkg::coord_t col;
   chess_pkg::coord_t row_off;
   chess_pkg::coord_t col_off;
   chess_pkg::coord_t square_row;
   chess_pkg::coord_t square_col;

   assign row_off    = chess_pkg::row_offset[kind][dir];
   assign col_off    = chess_pkg::col_offset[kind][dir];
   assign square_row = chess_pkg::coord_t'({2'b00, square[5:3]});
   assign square_col = chess_pkg::coord_t'({2'b00, square[2:0]});

   always_ff @(posedge clk)
   begin
      if (dir_start)
      begin
         row <= square_row + row_off;   // first target of the ray
         col <= square_col + col_off;
      end
      else if (step)
      begin
         row <= row + row_off;
         col <= col + col_off;
      end
   end

   assign target = {row[2:0], col[2:0]};

   // both coordinates within 0..7
   assign on_board = (row[4:3] == 2'b00) && (col[4:3] == 2'b00);

   assign is_slider = chess_pkg::slider_kinds[kind];
   assign dir_last  = ({1'b0, dir} == chess_pkg::dir_count[kind] - 4'd1);

endmodule

//--- source/square_counter.sv
`timescale 1ns/100ps

module square_counter
(
   input  logic               clk,
   input  logic               reset,
   input  logic               load,
   input  logic               next_square,
   input  logic               next_dir,
   input  logic               dir_start,
   output chess_pkg::square_t square,
   output chess_pkg::dir_t    dir
);

   logic active;   // set once a board is loaded

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         square <= '0;
         dir    <= '0;
         active <= 1'b0;
      end
      else if (load)
      begin
         square <= '0;
         dir    <= '0;
         active <= 1'b1;
      end
      else if (next_square)
      begin
         square <= square + chess_pkg::square_t'(1);
         dir    <= '0;   // new piece starts at its first direction
      end
      else if (next_dir)
         dir <= dir + chess_pkg::dir_t'(1);
   end

   // scan runs only after a load and ends at h8 without wrapping
   assert property (@(posedge clk) disable iff (reset)
      (next_square || dir_start) |-> active && !(next_square && &square));

endmodule

//--- source/move_gen_fsm.sv
`timescale 1ns/100ps

module move_gen_fsm
(
   input  logic clk,
   input  logic reset,
   input  logic board_valid,
   input  logic clear_moves,
   input  logic own_piece,
   input  logic is_slider,
   input  logic dir_last,
   input  logic square_last,
   input  logic on_board,
   input  logic target_empty,
   input  logic target_enemy,
   output logic load,
   output logic dir_start,
   output logic step,
   output logic next_dir,
   output logic next_square,
   output logic record,
   output logic moves_ready
);

   typedef enum logic [2:0]
   {
      state_idle,
      state_scan,
      state_dir_init,
      state_probe,
      state_advance,
      state_done
   } state_t;

   state_t state;
   state_t state_next;
   logic   dir_done;   // current ray finished

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= state_idle;
      else
         state <= state_next;
   end

   always_comb
   begin
      load        = 1'b0;
      dir_start   = 1'b0;
      step        = 1'b0;
      next_dir    = 1'b0;
      next_square = 1'b0;
      record      = 1'b0;
      dir_done    = 1'b0;
      state_next  = state;
      case (state)
         state_idle:
            if (board_valid)
            begin
               load       = 1'b1;
               state_next = state_scan;
            end
         state_scan:
            if (own_piece)
               state_next = state_dir_init;
            else if (square_last)
               state_next = state_done;
            else
               next_square = 1'b1;   // stay in scan
         state_dir_init:
         begin
            dir_start  = 1'b1;
            state_next = state_probe;
         end
         state_probe:
            if (on_board && (target_empty || target_enemy))
            begin
               record     = 1'b1;
               state_next = state_advance;
            end
            else
               dir_done = 1'b1;   // edge or own piece
         state_advance:
            if (is_slider && target_empty)
            begin
               step       = 1'b1;
               state_next = state_probe;
            end
            else
               dir_done = 1'b1;
         state_done:
            if (clear_moves)
               state_next = state_idle;
         default:
            state_next = state_idle;
      endcase

      if (dir_done)
      begin
         if (!dir_last)
         begin
            next_dir   = 1'b1;
            state_next = state_dir_init;
         end
         else if (square_last)
            state_next = state_done;
         else
         begin
            next_square = 1'b1;
            state_next  = state_scan;
         end
      end
   end

   assign moves_ready = (state == state_done);

   // a move is only stored from a probed target
   assert property (@(posedge clk) disable iff (reset) record |-> state == state_probe);

   assert property (@(posedge clk) reset |=> !moves_ready);

endmodule

//--- source/chess_pkg.sv
package chess_pkg;

   typedef logic [3:0]        piece_t;    // bit 3 black, 2..0 kind
   typedef logic [255:0]      board_t;    // square n at bits 4n+3..4n
   typedef logic [5:0]        square_t;   // row * 8 + col
   typedef logic signed [4:0] coord_t;    // room to step off the board
   typedef logic [2:0]        dir_t;
   typedef logic [6:0]        move_index_t;
   typedef logic [7:0]        move_count_t;

   localparam logic [2:0] piece_empty  = 3'd0;
   localparam logic [2:0] piece_pawn   = 3'd1;
   localparam logic [2:0] piece_knight = 3'd2;
   localparam logic [2:0] piece_bishop = 3'd3;
   localparam logic [2:0] piece_rook   = 3'd4;
   localparam logic [2:0] piece_queen  = 3'd5;
   localparam logic [2:0] piece_king   = 3'd6;

   localparam int black_bit = 3;

   localparam int max_moves = 128;

   // offsets indexed by [kind][dir]
   localparam coord_t row_offset [0:7][0:7] = '{
      '{ 0,  0,  0,  0,  0,  0,  0,  0},   // empty
      '{ 0,  0,  0,  0,  0,  0,  0,  0},   // pawn
      '{-2, -1,  1,  2,  2,  1, -1, -2},   // knight
      '{ 1,  1, -1, -1,  0,  0,  0,  0},   // bishop
      '{ 0,  0,  1, -1,  0,  0,  0,  0},   // rook
      '{-1, -1, -1,  0,  0,  1,  1,  1},   // queen
      '{-1, -1, -1,  0,  0,  1,  1,  1},   // king
      '{ 0,  0,  0,  0,  0,  0,  0,  0}
   };

   localparam coord_t col_offset [0:7][0:7] = '{
      '{ 0,  0,  0,  0,  0,  0,  0,  0},
      '{ 0,  0,  0,  0,  0,  0,  0,  0},
      '{-1, -2, -2, -1,  1,  2,  2,  1},
      '{ 1, -1,  1, -1,  0,  0,  0,  0},
      '{ 1, -1,  0,  0,  0,  0,  0,  0},
      '{-1,  0,  1, -1,  1, -1,  0,  1},
      '{-1,  0,  1, -1,  1, -1,  0,  1},
      '{ 0,  0,  0,  0,  0,  0,  0,  0}
   };

   localparam logic [3:0] dir_count [0:7] = '{0, 0, 8, 4, 4, 8, 8, 0};

   // bishop, rook and queen keep walking
   localparam logic [7:0] slider_kinds = 8'b0011_1000;

endpackage
